/* src/bp_pkg.sv */
package bp_pkg;

	// PC and BTB geometry
	localparam int WORD_SIZE = 16;
	localparam int IDX_SIZE = 4; // Low PC bits that pick a BTB entry
	localparam int TAG_SIZE = WORD_SIZE - IDX_SIZE;
	localparam int BTB_ENTRIES = 1 << IDX_SIZE;

	// Program bounds
	localparam logic [WORD_SIZE-1:0] RESET_PC = 16'h0000;
	localparam logic [WORD_SIZE-1:0] PC_LIMIT = 16'hc6; // Fetch stops here

	// Prediction tracker queue
	localparam int QUEUE_DEPTH = 4; // Unresolved fetches in flight
	localparam int QPTR_SIZE = $clog2(QUEUE_DEPTH);

	typedef logic [WORD_SIZE-1:0] word_t;

	// One fetched instruction and the next PC that fetch guessed for it
	typedef struct packed {
		word_t pc;
		word_t pred_pc;
	} pred_entry_t;

endpackage

/* src/btb_if.sv */
`timescale 1ns/1ps

interface btb_if;
	import bp_pkg::*;

	// Lookup side answered in the same cycle
	word_t lookup_pc;
	logic hit;
	word_t target;

	// Update side written at the next clock edge
	logic update_en;
	word_t update_pc;
	word_t update_target;

	modport fetch (
		output lookup_pc,
		input hit,
		input target
	);

	modport tracker (
		output update_en,
		output update_pc,
		output update_target
	);

	modport tbl (
		input lookup_pc,
		output hit,
		output target,
		input update_en,
		input update_pc,
		input update_target
	);

endinterface

/* src/btb.sv */
`timescale 1ns/1ps

module btb (
	input logic clk,
	input logic reset_n,
	btb_if.tbl bus
);
	import bp_pkg::*;

	logic [BTB_ENTRIES-1:0] valid; // One bit per entry
	logic [TAG_SIZE-1:0] tag_table [BTB_ENTRIES];
	word_t target_table [BTB_ENTRIES];

	logic [IDX_SIZE-1:0] lookup_idx;
	logic [TAG_SIZE-1:0] lookup_tag;
	logic [IDX_SIZE-1:0] update_idx;
	logic [TAG_SIZE-1:0] update_tag;
	logic tag_match;

	// Split the lookup PC into index and tag
	assign lookup_idx = bus.lookup_pc[IDX_SIZE-1:0];
	assign lookup_tag = bus.lookup_pc[WORD_SIZE-1:IDX_SIZE];

	// Same split for the resolved PC
	assign update_idx = bus.update_pc[IDX_SIZE-1:0];
	assign update_tag = bus.update_pc[WORD_SIZE-1:IDX_SIZE];

	// Valid bits start cleared so an empty table never hits
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid <= '0;
		end else if (bus.update_en) begin
			valid[update_idx] <= 1'b1;
		end
	end

	// Tag and target storage
	always_ff @(posedge clk) begin
		if (bus.update_en) begin
			tag_table[update_idx] <= update_tag;
			target_table[update_idx] <= bus.update_target;
		end
	end

	// Lookup reads the old contents during an update cycle
	assign tag_match = (tag_table[lookup_idx] == lookup_tag);
	assign bus.hit = valid[lookup_idx] && tag_match;

	// Target is only meaningful on a hit
	always_comb begin
		if (bus.hit) begin
			bus.target = target_table[lookup_idx];
		end else begin
			bus.target = '0;
		end
	end

endmodule

/* src/fetch_pc.sv */
`timescale 1ns/1ps

module fetch_pc (
	input logic clk,
	input logic reset_n,
	input logic stall,
	input logic full,
	input logic flush,
	input bp_pkg::word_t redirect_pc,
	output logic push,
	output bp_pkg::pred_entry_t entry,
	output logic fetch_valid,
	output bp_pkg::word_t fetch_pc,
	btb_if.fetch bus
);
	import bp_pkg::*;

	word_t pc_q; // Address of the next fetch
	word_t pred_pc; // Guessed address after pc_q
	logic run; // Low until the first cycle after reset
	logic in_program;
	logic can_fetch;

	// Ask the BTB about the current PC
	assign bus.lookup_pc = pc_q;

	// Always taken on a hit, otherwise fall through
	always_comb begin
		if (bus.hit) begin
			pred_pc = bus.target;
		end else begin
			pred_pc = pc_q + 16'd1;
		end
	end

	assign in_program = (pc_q < PC_LIMIT);

	// A fetch issues only when nothing holds it back
	assign can_fetch = run && !stall && !full && !flush && in_program;

	assign fetch_valid = can_fetch;
	assign fetch_pc = pc_q;
	assign push = can_fetch;
	assign entry = '{pc: pc_q, pred_pc: pred_pc};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			run <= 1'b0;
		end else begin
			run <= 1'b1;
		end
	end

	// PC register
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc_q <= RESET_PC;
		end else if (flush) begin
			pc_q <= redirect_pc; // Resolve stage wins over prediction
		end else if (can_fetch) begin
			pc_q <= pred_pc;
		end
	end

endmodule

/* src/pred_tracker.sv */
`timescale 1ns/1ps

module pred_tracker (
	input logic clk,
	input logic reset_n,
	input logic push,
	input bp_pkg::pred_entry_t entry,
	input logic resolve_valid,
	input logic resolve_is_bj,
	input bp_pkg::word_t resolve_target,
	input bp_pkg::word_t resolve_next_pc,
	output logic full,
	output logic flush,
	output bp_pkg::word_t redirect_pc,
	btb_if.tracker bus
);
	import bp_pkg::*;

	localparam logic [QPTR_SIZE:0] COUNT_FULL = (QPTR_SIZE + 1)'(QUEUE_DEPTH);

	pred_entry_t queue [QUEUE_DEPTH]; // Fetches still waiting for resolve
	logic [QPTR_SIZE-1:0] rd_ptr;
	logic [QPTR_SIZE-1:0] wr_ptr;
	logic [QPTR_SIZE:0] count;
	pred_entry_t head;
	logic pop;
	logic mispredict;

	// Oldest unresolved fetch
	assign head = queue[rd_ptr];

	// Reports come in fetch order so each one pops the head
	assign pop = resolve_valid;

	assign full = (count == COUNT_FULL);

	// Compare the guess with where the program really went
	assign mispredict = (resolve_next_pc != head.pred_pc);
	assign flush = pop && mispredict;
	assign redirect_pc = resolve_next_pc;

	// Learn the target of every branch or jump that resolves
	assign bus.update_en = pop && resolve_is_bj;
	assign bus.update_pc = head.pc;
	assign bus.update_target = resolve_target;

	// Payload storage
	always_ff @(posedge clk) begin
		if (push) begin
			queue[wr_ptr] <= entry;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			// Everything younger than the head was fetched down the wrong path
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

/* src/bp_top.sv */
`timescale 1ns/1ps

module bp_top (
	input logic clk,
	input logic reset_n,
	input logic stall,
	input logic resolve_valid,
	input logic resolve_is_bj,
	input bp_pkg::word_t resolve_target,
	input bp_pkg::word_t resolve_next_pc,
	output logic fetch_valid,
	output bp_pkg::word_t fetch_pc,
	output logic flush
);
	import bp_pkg::*;

	logic push; // New fetch entering the tracker
	pred_entry_t entry;
	logic full;
	word_t redirect_pc;

	// Shared lookup and update path
	btb_if btb_bus ();

	btb u_btb (
		.clk(clk),
		.reset_n(reset_n),
		.bus(btb_bus.tbl)
	);

	fetch_pc u_fetch (
		.clk(clk),
		.reset_n(reset_n),
		.stall(stall),
		.full(full),
		.flush(flush),
		.redirect_pc(redirect_pc),
		.push(push),
		.entry(entry),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.bus(btb_bus.fetch)
	);

	pred_tracker u_tracker (
		.clk(clk),
		.reset_n(reset_n),
		.push(push),
		.entry(entry),
		.resolve_valid(resolve_valid),
		.resolve_is_bj(resolve_is_bj),
		.resolve_target(resolve_target),
		.resolve_next_pc(resolve_next_pc),
		.full(full),
		.flush(flush),
		.redirect_pc(redirect_pc),
		.bus(btb_bus.tracker)
	);

endmodule

/* tb/bp_chk.sv */
`timescale 1ns/1ps

module bp_chk (
	input logic clk,
	input logic reset_n,
	input logic push,
	input bp_pkg::pred_entry_t entry,
	input logic resolve_valid,
	input logic flush,
	input logic [bp_pkg::QPTR_SIZE:0] count
);
	import bp_pkg::*;

	int fail_count = 0; // Failed assertions so far

	resolve_needs_entry: assert property (@(posedge clk) disable iff (!reset_n)
		resolve_valid |-> count != '0)
		else begin
			$error("Resolve arrived with no fetch in flight");
			fail_count++;
		end

	count_in_range: assert property (@(posedge clk) disable iff (!reset_n)
		count <= (QPTR_SIZE + 1)'(QUEUE_DEPTH))
		else begin
			$error("Tracker count above queue depth");
			fail_count++;
		end

	// Fetch idles in the first cycle out of reset
	no_fetch_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !push)
		else begin
			$error("Fetch issued in the first cycle after reset");
			fail_count++;
		end

	no_fetch_on_flush: assert property (@(posedge clk) disable iff (!reset_n)
		flush |-> !push)
		else begin
			$error("Fetch issued during a flush");
			fail_count++;
		end

	fetch_in_program: assert property (@(posedge clk) disable iff (!reset_n)
		push |-> entry.pc < PC_LIMIT)
		else begin
			$error("Fetch at or beyond the end of the program");
			fail_count++;
		end

endmodule

bind pred_tracker bp_chk u_chk (
	.clk(clk), .reset_n(reset_n), .push(push), .entry(entry),
	.resolve_valid(resolve_valid), .flush(flush), .count(count)
);

/* tb/bp_tb.sv */
`timescale 1ns/1ps

module bp_tb;
	import bp_pkg::*;

	localparam int PROG_SIZE = int'(PC_LIMIT);
	localparam int TAKE_LIMIT = 2; // Taken runs per branch before it falls through
	localparam int END_CYCLES = 5;

	logic clk = 1'b0;
	logic reset_n;
	logic stall;
	logic resolve_valid;
	logic resolve_is_bj;
	word_t resolve_target;
	word_t resolve_next_pc;
	logic fetch_valid;
	word_t fetch_pc;
	logic flush;

	logic [15:0] lfsr_state;
	logic prog_bj [PROG_SIZE]; // Program model, one entry per address
	logic prog_taken [PROG_SIZE];
	word_t prog_target [PROG_SIZE];
	word_t trace_pc [$]; // Real path in execution order
	word_t trace_next [$];

	logic ref_valid [BTB_ENTRIES] = '{default: 1'b0};
	word_t ref_tag [BTB_ENTRIES];
	word_t ref_target [BTB_ENTRIES];
	word_t ref_pc = RESET_PC;
	word_t inflight_pc [$]; // Fetches not yet resolved
	word_t inflight_pred [$];
	logic run_seen = 1'b0;
	logic exp_flush;
	logic exp_fetch;
	word_t pred;
	int res_idx = 0;
	int cycles = 0;
	int timeout_limit;

	always #10 clk = ~clk;

	bp_top u_dut (.*);

	// Galois LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hb400;
		end
		return state >> 1;
	endfunction

	function automatic int random_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	// Always-taken policy on the testbench's own table
	function automatic word_t predict(input word_t pc);
		int idx;
		idx = int'(pc[IDX_SIZE-1:0]);
		if (ref_valid[idx] && ref_tag[idx] == (pc >> IDX_SIZE)) begin
			return ref_target[idx];
		end
		return pc + 16'd1;
	endfunction

	task automatic learn(input word_t pc, input word_t target);
		int idx;
		idx = int'(pc[IDX_SIZE-1:0]);
		ref_valid[idx] = 1'b1;
		ref_tag[idx] = pc >> IDX_SIZE;
		ref_target[idx] = target;
	endtask

	task automatic build_program();
		int pc;
		int taken_cnt [PROG_SIZE];
		word_t next_pc;
		for (int a = 0; a < PROG_SIZE; a++) begin
			prog_bj[a] = ((random_bits(5) % 6) == 0); // Roughly one in six
			prog_taken[a] = (random_bits(1) == 1);
			prog_target[a] = prog_bj[a] ? word_t'(random_bits(8) % PROG_SIZE) : '0;
			taken_cnt[a] = 0;
		end
		// Walk the real path once so every resolve outcome is known
		pc = int'(RESET_PC);
		while (pc < PROG_SIZE) begin
			next_pc = word_t'(pc + 1);
			if (prog_bj[pc] && prog_taken[pc] && taken_cnt[pc] < TAKE_LIMIT) begin
				next_pc = prog_target[pc];
				taken_cnt[pc]++;
			end
			trace_pc.push_back(word_t'(pc));
			trace_next.push_back(next_pc);
			pc = int'(next_pc);
		end
	endtask

	task automatic check_value(input word_t actual, input word_t expected, input string what);
		if (actual !== expected) begin
			$display("Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("** FAIL **");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Compare mid-cycle, then advance the model to the next edge
	always @(negedge clk) begin
		if (reset_n) begin
			cycles++;
			if (cycles > timeout_limit) begin
				$display("Timeout after %0d cycles, the program never finished", cycles);
				$display("** FAIL **");
				$fatal(1, "Run did not finish");
			end else begin
				exp_flush = 1'b0;
				if (resolve_valid) begin
					check_value(u_dut.u_tracker.head.pc, trace_pc[res_idx], "resolved pc");
					exp_flush = (resolve_next_pc != inflight_pred[0]);
				end
				exp_fetch = run_seen && !stall && !exp_flush && ref_pc < PC_LIMIT
					&& inflight_pc.size() < QUEUE_DEPTH;
				check_value(word_t'(flush), word_t'(exp_flush), "flush");
				check_value(word_t'(fetch_valid), word_t'(exp_fetch), "fetch_valid");
				if (exp_fetch) begin
					check_value(fetch_pc, ref_pc, "fetch_pc");
				end
				pred = predict(ref_pc); // Sees the table before this cycle's update
				if (resolve_valid) begin
					if (resolve_is_bj) begin
						learn(inflight_pc[0], resolve_target);
					end
					void'(inflight_pc.pop_front());
					void'(inflight_pred.pop_front());
					res_idx++;
				end
				if (exp_flush) begin
					ref_pc = resolve_next_pc;
					inflight_pc.delete();
					inflight_pred.delete();
				end else if (exp_fetch) begin
					inflight_pc.push_back(ref_pc);
					inflight_pred.push_back(pred);
					ref_pc = pred;
				end
				run_seen = 1'b1;
			end
		end
	end

	initial begin
		reset_n = 1'b0;
		stall = 1'b0;
		resolve_valid = 1'b0;
		resolve_is_bj = 1'b0;
		resolve_target = '0;
		resolve_next_pc = '0;
		lfsr_state = 16'd72;
		build_program();
		timeout_limit = 20 * trace_pc.size();
		repeat (3) @(posedge clk);
		#1;
		reset_n = 1'b1;
		// Play the resolve stage until every instruction on the real path retires
		do begin
			@(posedge clk);
			#1;
			stall = (random_bits(3) == 0); // About one cycle in eight
			if (res_idx < trace_pc.size() && inflight_pc.size() > 0 && random_bits(1) == 1) begin
				resolve_valid = 1'b1;
				resolve_is_bj = prog_bj[int'(trace_pc[res_idx])];
				resolve_target = prog_target[int'(trace_pc[res_idx])];
				resolve_next_pc = trace_next[res_idx];
			end else begin
				resolve_valid = 1'b0;
				resolve_is_bj = 1'b0;
			end
		end while (res_idx < trace_pc.size());
		repeat (END_CYCLES) @(negedge clk); // Fetch stays idle at the program end
		@(posedge clk);
		#1;
		check_value(fetch_pc, PC_LIMIT, "fetch_pc at program end");
		if (u_dut.u_tracker.u_chk.fail_count == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("Bound assertions failed during the run");
			$display("** FAIL **");
			$fatal(1, "Assertion failures");
		end
	end

endmodule

/* verilog.f */
src/bp_pkg.sv
src/btb_if.sv
src/btb.sv
src/fetch_pc.sv
src/pred_tracker.sv
src/bp_top.sv
tb/bp_chk.sv
tb/bp_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := bp_tb
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q -F "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
